//--- common/rob_dispatch_pkg.sv
// types for the dispatch path, widths follow the settings header and must be set there
`include "rob_dispatch_settings.svh"

package rob_dispatch_pkg;

	// an index into the issue queue
	typedef logic [$clog2(`RD_QENTRIES)-1:0] qidx_t;

	// occupancy of the issue queue, needs one extra bit to reach the full count
	typedef logic [$clog2(`RD_QENTRIES+1)-1:0] qcnt_t;

	// a reorder buffer entry id
	typedef logic [$clog2(`RD_RENTRIES)-1:0] rid_t;

	// number of slots used in one cycle, from zero up to RD_RSLOTS
	typedef logic [$clog2(`RD_RSLOTS+1)-1:0] slot_cnt_t;

	// instruction tag as handed in by fetch
	typedef logic [`RD_TAG_W-1:0] tag_t;

	// an entry waits in IQ_WAIT until it owns a ROB id, then sits in IQ_ISSUED until retired
	typedef enum logic [1:0] {
		IQ_EMPTY,
		IQ_WAIT,
		IQ_ISSUED
	} iq_state_e;

	// ==================================================
	// interface payloads
	// ==================================================

	typedef struct packed {
		logic valid;
		tag_t tag;
	} fetch_s;

	typedef struct packed {
		logic valid;
		rid_t rid;
		qidx_t qidx;
		tag_t tag;
	} issue_s;

	typedef struct packed {
		logic valid;
		rid_t rid;
		tag_t tag;
	} commit_s;

	typedef struct packed {
		logic valid;
		rid_t rid;
	} complete_s;

	// a commit slot as the ROB sends it back, with the queue entry it frees
	typedef struct packed {
		commit_s cmt;
		qidx_t qidx;
	} retire_s;

endpackage

//--- common/rob_dispatch_settings.svh
// sizes must satisfy RD_RENTRIES <= RD_QENTRIES and RD_RSLOTS <= RD_RENTRIES, depths need not be powers of two
`ifndef ROB_DISPATCH_SETTINGS_SVH
`define ROB_DISPATCH_SETTINGS_SVH

// ==================================================
// issue queue
// ==================================================

// number of instruction slots waiting for or holding a ROB entry
`define RD_QENTRIES 8

// ==================================================
// reorder buffer
// ==================================================

// kept smaller than the queue so that a full ROB is what stalls allocation
`define RD_RENTRIES 4

// allocations per cycle and retirements per cycle share this limit
`define RD_RSLOTS 2

// width of the instruction tag carried from fetch to commit
`define RD_TAG_W 8

`endif

//--- hdl/issue_queue.sv
// in-order circular queue, retirement must free the oldest entries first since only the oldest pointer moves
`include "rob_dispatch_settings.svh"

module issue_queue (
	input  logic                                            clk,
	input  logic                                            rst,
	input  rob_dispatch_pkg::fetch_s                        fetch_i,
	output logic                                            in_ready_o,
	output rob_dispatch_pkg::qidx_t                         order_o [`RD_QENTRIES],
	output rob_dispatch_pkg::iq_state_e                     state_o [`RD_QENTRIES],
	output rob_dispatch_pkg::tag_t                          tag_o [`RD_QENTRIES],
	input  rob_dispatch_pkg::issue_s  [`RD_RSLOTS-1:0]     issue_i,
	input  rob_dispatch_pkg::retire_s [`RD_RSLOTS-1:0]     commit_i
);

	// ==================================================
	// storage and pointers
	// ==================================================

	rob_dispatch_pkg::iq_state_e state_q [`RD_QENTRIES];
	rob_dispatch_pkg::tag_t      tag_q [`RD_QENTRIES];

	// next free slot, and the oldest entry still held
	rob_dispatch_pkg::qidx_t     wr_ptr_q;
	rob_dispatch_pkg::qidx_t     old_ptr_q;
	rob_dispatch_pkg::qcnt_t     count_q;

	rob_dispatch_pkg::slot_cnt_t ret_cnt;
	logic                        accept;

	// step an index around the ring, depth need not be a power of two
	function automatic rob_dispatch_pkg::qidx_t qadd(input rob_dispatch_pkg::qidx_t base,
		input int step);
		int sum;
		sum = (int'(base) + step) % `RD_QENTRIES;
		return rob_dispatch_pkg::qidx_t'(sum);
	endfunction

	// ready only looks at the registered count, so fetch never sees a loop through it
	assign in_ready_o = (count_q != rob_dispatch_pkg::qcnt_t'(`RD_QENTRIES));
	assign accept     = fetch_i.valid && in_ready_o;

	// commit slots arrive packed from slot 0, but count them all anyway
	always_comb begin : count_retire
		ret_cnt = '0;
		for (int s = 0; s < `RD_RSLOTS; s++) begin
			if (commit_i[s].cmt.valid) begin
				ret_cnt = ret_cnt + 1'b1;
			end
		end
	end

	// ==================================================
	// oldest-first view for the allocator
	// ==================================================

	// order_o[0] is the oldest entry, entries past the occupancy read as IQ_EMPTY
	always_comb begin : build_order
		for (int n = 0; n < `RD_QENTRIES; n++) begin
			order_o[n] = qadd(old_ptr_q, n);
			state_o[n] = state_q[n];
			tag_o[n]   = tag_q[n];
		end
	end

	// ==================================================
	// state updates
	// ==================================================

	// the three updates never touch the same entry in one cycle
	// a new entry lands on an empty slot, issue needs IQ_WAIT and retire needs IQ_ISSUED
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr_q  <= '0;
			old_ptr_q <= '0;
			count_q   <= '0;
			for (int n = 0; n < `RD_QENTRIES; n++) begin
				state_q[n] <= rob_dispatch_pkg::IQ_EMPTY;
			end
		end else begin
			for (int s = 0; s < `RD_RSLOTS; s++) begin
				if (issue_i[s].valid) begin
					state_q[issue_i[s].qidx] <= rob_dispatch_pkg::IQ_ISSUED;
				end
			end
			// retired entries are by construction the oldest ones
			for (int s = 0; s < `RD_RSLOTS; s++) begin
				if (commit_i[s].cmt.valid) begin
					state_q[commit_i[s].qidx] <= rob_dispatch_pkg::IQ_EMPTY;
				end
			end
			if (accept) begin
				state_q[wr_ptr_q] <= rob_dispatch_pkg::IQ_WAIT;
				wr_ptr_q          <= qadd(wr_ptr_q, 1);
			end
			old_ptr_q <= qadd(old_ptr_q, int'(ret_cnt));
			count_q   <= count_q + rob_dispatch_pkg::qcnt_t'(accept)
				- rob_dispatch_pkg::qcnt_t'(ret_cnt);
		end
	end

	// the tag is payload and is only meaningful while the state says so
	always_ff @(posedge clk) begin
		if (accept) begin
			tag_q[wr_ptr_q] <= fetch_i.tag;
		end
	end

endmodule

//--- hdl/rob_alloc.sv
// purely combinational, the caller must present order_i oldest first and a registered ROB view
`include "rob_dispatch_settings.svh"

module rob_alloc (
	input  rob_dispatch_pkg::qidx_t                     order_i [`RD_QENTRIES],
	input  rob_dispatch_pkg::iq_state_e                 state_i [`RD_QENTRIES],
	input  rob_dispatch_pkg::tag_t                      tag_i [`RD_QENTRIES],
	input  rob_dispatch_pkg::rid_t                      tail_i,
	input  logic [`RD_RENTRIES-1:0]                     rob_v_i,
	output rob_dispatch_pkg::issue_s [`RD_RSLOTS-1:0]   issue_o
);

	// ==================================================
	// age-ordered allocation
	// ==================================================

	// next rid along the ROB ring
	function automatic rob_dispatch_pkg::rid_t rnext(input rob_dispatch_pkg::rid_t r);
		int sum;
		sum = (int'(r) + 1) % `RD_RENTRIES;
		return rob_dispatch_pkg::rid_t'(sum);
	endfunction

	// walk the queue oldest first and hand out rids from the tail
	// the first waiting entry that cannot get a rid blocks every younger one,
	// which keeps ROB order equal to program order
	always_comb begin : alloc_walk
		rob_dispatch_pkg::rid_t  next_rid;
		rob_dispatch_pkg::qidx_t idx;
		int                      slot;
		logic                    blocked;

		next_rid = tail_i;
		slot     = 0;
		blocked  = 1'b0;
		issue_o  = '0;
		for (int n = 0; n < `RD_QENTRIES; n++) begin
			idx = order_i[n];
			// issued entries are older than any waiting one, empty ones are younger
			if (state_i[idx] == rob_dispatch_pkg::IQ_WAIT && !blocked) begin
				if (!rob_v_i[next_rid] && slot < `RD_RSLOTS) begin
					issue_o[slot].valid = 1'b1;
					issue_o[slot].rid   = next_rid;
					issue_o[slot].qidx  = idx;
					issue_o[slot].tag   = tag_i[idx];
					next_rid            = rnext(next_rid);
					slot                = slot + 1;
				end else begin
					// either the tail slot is still busy or this cycle's slots are used up
					blocked = 1'b1;
				end
			end
		end
	end

endmodule

//--- hdl/rob_dispatch_top.sv
// issue_o and commit_o slots act at the next edge with no ready, the outside must always take them
`include "rob_dispatch_settings.svh"

module rob_dispatch_top (
	input  logic                                        clk,
	input  logic                                        rst,
	input  rob_dispatch_pkg::fetch_s                    fetch_i,
	output logic                                        in_ready_o,
	output rob_dispatch_pkg::issue_s  [`RD_RSLOTS-1:0]  issue_o,
	input  rob_dispatch_pkg::complete_s                 complete_i,
	output rob_dispatch_pkg::commit_s [`RD_RSLOTS-1:0]  commit_o
);

	// ==================================================
	// internal nets
	// ==================================================

	// oldest-first view of the queue for the allocator
	rob_dispatch_pkg::qidx_t     order_w [`RD_QENTRIES];
	rob_dispatch_pkg::iq_state_e state_w [`RD_QENTRIES];
	rob_dispatch_pkg::tag_t      tag_w [`RD_QENTRIES];

	// ROB occupancy seen by the allocator
	rob_dispatch_pkg::rid_t      tail_w;
	logic [`RD_RENTRIES-1:0]     rob_v_w;

	rob_dispatch_pkg::issue_s  [`RD_RSLOTS-1:0] issue_w;
	rob_dispatch_pkg::retire_s [`RD_RSLOTS-1:0] retire_w;

	issue_queue u_queue (
		.clk        (clk),
		.rst        (rst),
		.fetch_i    (fetch_i),
		.in_ready_o (in_ready_o),
		.order_o    (order_w),
		.state_o    (state_w),
		.tag_o      (tag_w),
		.issue_i    (issue_w),
		.commit_i   (retire_w)
	);

	rob_alloc u_alloc (
		.order_i (order_w),
		.state_i (state_w),
		.tag_i   (tag_w),
		.tail_i  (tail_w),
		.rob_v_i (rob_v_w),
		.issue_o (issue_w)
	);

	rob_table u_rob (
		.clk        (clk),
		.rst        (rst),
		.issue_i    (issue_w),
		.complete_i (complete_i),
		.tail_o     (tail_w),
		.rob_v_o    (rob_v_w),
		.commit_o   (retire_w)
	);

	// the allocator result goes out as is, the queue index stays inside on commit
	assign issue_o = issue_w;

	for (genvar s = 0; s < `RD_RSLOTS; s++) begin : g_commit
		assign commit_o[s] = retire_w[s].cmt;
	end

endmodule

//--- rob/rob_table.sv
// completions must name an issued, not yet completed rid, anything else corrupts the done bits
`include "rob_dispatch_settings.svh"

module rob_table (
	input  logic                                        clk,
	input  logic                                        rst,
	input  rob_dispatch_pkg::issue_s  [`RD_RSLOTS-1:0]  issue_i,
	input  rob_dispatch_pkg::complete_s                 complete_i,
	output rob_dispatch_pkg::rid_t                      tail_o,
	output logic [`RD_RENTRIES-1:0]                     rob_v_o,
	output rob_dispatch_pkg::retire_s [`RD_RSLOTS-1:0]  commit_o
);

	// ==================================================
	// entry state
	// ==================================================

	logic [`RD_RENTRIES-1:0] valid_q;
	logic [`RD_RENTRIES-1:0] done_q;
	rob_dispatch_pkg::tag_t  tag_q [`RD_RENTRIES];
	rob_dispatch_pkg::qidx_t qidx_q [`RD_RENTRIES];

	// head is the oldest live entry, tail is the next one to hand out
	rob_dispatch_pkg::rid_t  head_q;
	rob_dispatch_pkg::rid_t  tail_q;

	rob_dispatch_pkg::slot_cnt_t iss_cnt;
	rob_dispatch_pkg::slot_cnt_t ret_cnt;

	// advance a rid around the ring by a slot count
	function automatic rob_dispatch_pkg::rid_t radd(input rob_dispatch_pkg::rid_t r,
		input rob_dispatch_pkg::slot_cnt_t n);
		int sum;
		sum = (int'(r) + int'(n)) % `RD_RENTRIES;
		return rob_dispatch_pkg::rid_t'(sum);
	endfunction

	assign tail_o  = tail_q;
	assign rob_v_o = valid_q;

	// the allocator packs its slots from 0, the tail moves by how many it used
	always_comb begin : count_issue
		iss_cnt = '0;
		for (int s = 0; s < `RD_RSLOTS; s++) begin
			if (issue_i[s].valid) begin
				iss_cnt = iss_cnt + 1'b1;
			end
		end
	end

	// ==================================================
	// in-order retirement
	// ==================================================

	// a run of valid and done entries starting at the head retires together,
	// and the first entry that is not done stops the run
	always_comb begin : retire_walk
		rob_dispatch_pkg::rid_t r;
		logic                   run;

		r        = head_q;
		run      = 1'b1;
		ret_cnt  = '0;
		commit_o = '0;
		for (int s = 0; s < `RD_RSLOTS; s++) begin
			if (run && valid_q[r] && done_q[r]) begin
				commit_o[s].cmt.valid = 1'b1;
				commit_o[s].cmt.rid   = r;
				commit_o[s].cmt.tag   = tag_q[r];
				commit_o[s].qidx      = qidx_q[r];
				ret_cnt               = ret_cnt + 1'b1;
				r                     = radd(r, 1);
			end else begin
				run = 1'b0;
			end
		end
	end

	// issue only targets entries that read invalid, retire only clears valid ones,
	// so the two never land on the same rid in one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			done_q  <= '0;
			head_q  <= '0;
			tail_q  <= '0;
		end else begin
			for (int s = 0; s < `RD_RSLOTS; s++) begin
				if (issue_i[s].valid) begin
					valid_q[issue_i[s].rid] <= 1'b1;
					done_q[issue_i[s].rid]  <= 1'b0;
				end
			end
			if (complete_i.valid) begin
				done_q[complete_i.rid] <= 1'b1;
			end
			for (int s = 0; s < `RD_RSLOTS; s++) begin
				if (commit_o[s].cmt.valid) begin
					valid_q[commit_o[s].cmt.rid] <= 1'b0;
				end
			end
			tail_q <= radd(tail_q, iss_cnt);
			head_q <= radd(head_q, ret_cnt);
		end
	end

	// tag and queue index ride along with the entry until it retires
	always_ff @(posedge clk) begin
		for (int s = 0; s < `RD_RSLOTS; s++) begin
			if (issue_i[s].valid) begin
				tag_q[issue_i[s].rid]  <= issue_i[s].tag;
				qidx_q[issue_i[s].rid] <= issue_i[s].qidx;
			end
		end
	end

endmodule

//--- rob_dispatch.f
+incdir+common
common/rob_dispatch_pkg.sv
hdl/issue_queue.sv
hdl/rob_alloc.sv
rob/rob_table.sv
hdl/rob_dispatch_top.sv
tb/rob_dispatch_props.sv
tb/rob_dispatch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator from the file list, run it, and decide
# pass or fail from the simulation log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module rob_dispatch_tb \
	-f rob_dispatch.f

# keep running past assertion errors so the testbench prints its closing lines
./obj_dir/Vrob_dispatch_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "^All checks passed$" sim.log; then
	echo "simulation PASSED"
	exit 0
else
	echo "simulation FAILED"
	exit 1
fi

//--- tb/rob_dispatch_props.sv
// trackers assume one reset at the start and tags counted up from zero in fetch order
`include "rob_dispatch_settings.svh"

module rob_dispatch_props (
	input logic                                       clk,
	input logic                                       rst,
	input rob_dispatch_pkg::fetch_s                   fetch_i,
	input logic                                       in_ready_o,
	input rob_dispatch_pkg::issue_s  [`RD_RSLOTS-1:0] issue_o,
	input rob_dispatch_pkg::commit_s [`RD_RSLOTS-1:0] commit_o
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [`RD_RSLOTS-1:0]  iss_v;
	logic [`RD_RSLOTS-1:0]  cmt_v;
	int                     iss_n;
	int                     cmt_n;
	// queue and ROB occupancy as seen from the ports
	int                     q_occ;
	int                     r_occ;
	int                     next_rid;
	rob_dispatch_pkg::tag_t next_iss_tag;
	rob_dispatch_pkg::tag_t next_cmt_tag;

	always_comb begin : slot_valids
		iss_n = 0;
		cmt_n = 0;
		for (int s = 0; s < `RD_RSLOTS; s++) begin
			iss_v[s] = issue_o[s].valid;
			cmt_v[s] = commit_o[s].valid;
			iss_n    = iss_n + int'(iss_v[s]);
			cmt_n    = cmt_n + int'(cmt_v[s]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			q_occ        <= 0;
			r_occ        <= 0;
			next_rid     <= 0;
			next_iss_tag <= '0;
			next_cmt_tag <= '0;
		end else begin
			q_occ        <= q_occ + int'(fetch_i.valid && in_ready_o) - cmt_n;
			r_occ        <= r_occ + iss_n - cmt_n;
			next_rid     <= (next_rid + iss_n) % `RD_RENTRIES;
			next_iss_tag <= next_iss_tag + rob_dispatch_pkg::tag_t'(iss_n);
			next_cmt_tag <= next_cmt_tag + rob_dispatch_pkg::tag_t'(cmt_n);
		end
	end

	// ==================================================
	// port rules
	// ==================================================

	a_reset_quiet: assert property (@(posedge clk) rst |=> (iss_v == '0 && cmt_v == '0))
		else $error("issue or commit slot valid in the cycle after a reset edge");

	// a valid vector of the form 0..011..1 has no bit in common with itself plus one
	a_packed: assert property (@(posedge clk) disable iff (rst)
		((iss_v & (iss_v + 1'b1)) == '0) && ((cmt_v & (cmt_v + 1'b1)) == '0))
		else $error("issue or commit slots not packed from slot 0");

	a_issue_head: assert property (@(posedge clk) disable iff (rst)
		iss_v[0] |-> (issue_o[0].tag == next_iss_tag && int'(issue_o[0].rid) == next_rid))
		else $error("oldest issue slot out of program order");

	a_commit_head: assert property (@(posedge clk) disable iff (rst)
		cmt_v[0] |-> commit_o[0].tag == next_cmt_tag)
		else $error("oldest commit slot out of program order");

	for (genvar s = 1; s < `RD_RSLOTS; s++) begin : g_step
		a_issue_step: assert property (@(posedge clk) disable iff (rst)
			iss_v[s] |-> issue_o[s].tag == rob_dispatch_pkg::tag_t'(issue_o[s-1].tag + 1'b1))
			else $error("issue slots within one cycle out of order");
		a_commit_step: assert property (@(posedge clk) disable iff (rst)
			cmt_v[s] |-> commit_o[s].tag == rob_dispatch_pkg::tag_t'(commit_o[s-1].tag + 1'b1))
			else $error("commit slots within one cycle out of order");
	end

	a_rob_bound: assert property (@(posedge clk) disable iff (rst)
		r_occ <= `RD_RENTRIES && (r_occ == `RD_RENTRIES -> iss_v == '0))
		else $error("ROB overfilled or issue while full");

	a_ready: assert property (@(posedge clk) disable iff (rst)
		in_ready_o == (q_occ != `RD_QENTRIES))
		else $error("in_ready_o disagrees with queue occupancy");

endmodule

bind rob_dispatch_top rob_dispatch_props u_props (
	.clk        (clk),
	.rst        (rst),
	.fetch_i    (fetch_i),
	.in_ready_o (in_ready_o),
	.issue_o    (issue_o),
	.commit_o   (commit_o)
);

//--- tb/rob_dispatch_tb.sv
// single reset at start, 200 sequential tags, outputs sampled at the falling edge where they are settled
`include "rob_dispatch_settings.svh"

module rob_dispatch_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_INSTR = 200;
	localparam int PERIOD    = 40;
	// forty cycles per instruction is far more than the pipeline ever needs
	localparam int WATCHDOG  = NUM_INSTR * 40 * PERIOD;

	logic                                      clk;
	logic                                      rst;
	rob_dispatch_pkg::fetch_s                  fetch_i;
	logic                                      in_ready_o;
	rob_dispatch_pkg::issue_s  [`RD_RSLOTS-1:0] issue_o;
	rob_dispatch_pkg::complete_s               complete_i;
	rob_dispatch_pkg::commit_s [`RD_RSLOTS-1:0] commit_o;

	// ==================================================
	// reference model state
	// ==================================================

	logic [31:0]             rng = 32'h18ae;
	int                      sent = 0;
	int                      accepted = 0;
	int                      issued = 0;
	int                      retired = 0;
	// rids that are issued and still waiting for their completion report
	int                      pending [$];
	logic [`RD_RENTRIES-1:0] busy = '0;
	logic                    fire = 1'b0;
	logic                    was_rst = 1'b1;
	int                      mismatch_errs = 0;
	int                      rule_errs = 0;

	rob_dispatch_top rob_dispatch_top_i (
		.clk        (clk),
		.rst        (rst),
		.fetch_i    (fetch_i),
		.in_ready_o (in_ready_o),
		.issue_o    (issue_o),
		.complete_i (complete_i),
		.commit_o   (commit_o)
	);

	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic compare_value(input string what, input int got, input int exp);
		assert (got == exp) else begin
			mismatch_errs++;
			$display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic require_rule(input logic ok, input string what);
		assert (ok) else begin
			rule_errs++;
			$display("Error at %0d ns: %s", $time, what);
		end
	endtask

	task automatic close_run(input logic timed_out);
		$display("mismatches: %0d, rule errors: %0d, timeouts: %0d",
			mismatch_errs, rule_errs, int'(timed_out));
		if (!timed_out && mismatch_errs == 0 && rule_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	// ==================================================
	// mirror of the port rules, one look per cycle
	// ==================================================

	always @(negedge clk) begin : mirror
		int   occ;
		logic gap;
		if (rst || was_rst) begin
			for (int s = 0; s < `RD_RSLOTS; s++) begin
				require_rule(!issue_o[s].valid && !commit_o[s].valid,
					"an issue or commit slot is valid during or right after reset");
			end
		end
		was_rst = rst;
		if (!rst) begin
			occ  = issued - retired;
			fire = fetch_i.valid && in_ready_o;
			require_rule(in_ready_o == (accepted - retired != `RD_QENTRIES),
				"in_ready_o does not follow the queue occupancy");
			require_rule(occ <= `RD_RENTRIES, "more instructions in flight than the ROB holds");
			require_rule(!(occ == `RD_RENTRIES && issue_o[0].valid),
				"an instruction issued while the ROB was full");
			// issues see the ROB as it was before this edge's retirements
			gap = 1'b0;
			for (int s = 0; s < `RD_RSLOTS; s++) begin
				if (issue_o[s].valid) begin
					require_rule(!gap, "issue slots are not packed from slot 0");
					compare_value("issue tag", int'(issue_o[s].tag),
						int'(rob_dispatch_pkg::tag_t'(issued)));
					compare_value("issue rid", int'(issue_o[s].rid), issued % `RD_RENTRIES);
					// fetch fills the ring in order, so the n-th instruction sits at n mod depth
					compare_value("issue qidx", int'(issue_o[s].qidx), issued % `RD_QENTRIES);
					require_rule(!busy[issue_o[s].rid], "a rid issued again before it retired");
					busy[issue_o[s].rid] = 1'b1;
					pending.push_back(int'(issue_o[s].rid));
					issued++;
				end else begin
					gap = 1'b1;
				end
			end
			gap = 1'b0;
			for (int s = 0; s < `RD_RSLOTS; s++) begin
				if (commit_o[s].valid) begin
					require_rule(!gap, "commit slots are not packed from slot 0");
					compare_value("commit tag", int'(commit_o[s].tag),
						int'(rob_dispatch_pkg::tag_t'(retired)));
					compare_value("commit rid", int'(commit_o[s].rid), retired % `RD_RENTRIES);
					require_rule(busy[commit_o[s].rid],
						"a commit retired a rid that was not in flight");
					busy[commit_o[s].rid] = 1'b0;
					retired++;
				end else begin
					gap = 1'b1;
				end
			end
			if (fire) begin
				accepted++;
			end
		end
	end

	// ==================================================
	// stimulus and completion model
	// ==================================================

	initial begin : stimulus
		int pick;
		clk        = 1'b0;
		rst        = 1'b1;
		fetch_i    = '0;
		complete_i = '0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		while (retired < NUM_INSTR) begin
			rng           = next_random(rng);
			fetch_i.valid = (sent < NUM_INSTR) && (rng[2:0] != 3'd0);
			fetch_i.tag   = rob_dispatch_pkg::tag_t'(sent);
			complete_i    = '0;
			// completions come in random order and skip some cycles to let the ROB fill
			if (pending.size() > 0 && rng[4:3] != 2'd0) begin
				pick             = int'(rng[15:8]) % pending.size();
				complete_i.valid = 1'b1;
				complete_i.rid   = rob_dispatch_pkg::rid_t'(pending[pick]);
				pending.delete(pick);
			end
			@(posedge clk);
			#2;
			// the tag moves on only once the edge just passed has taken it
			if (fire) begin
				sent++;
			end
		end
		close_run(1'b0);
	end

	initial begin : watchdog
		#(WATCHDOG);
		$display("Timeout: the run timed out with %0d of %0d instructions still outstanding",
			NUM_INSTR - retired, NUM_INSTR);
		close_run(1'b1);
	end

endmodule
